// File: src/axi_pkg.sv
package axi_pkg;

  // Bus geometry shared by the AXI and AXI-Lite sides
  localparam int AXI_ADDR_W = 6;
  localparam int AXI_DATA_W = 16;
  localparam int AXI_ID_W   = 4;
  localparam int AXI_USER_W = 2;

  // log2 of the number of reads that may be outstanding at once
  localparam int OUTSTANDING_W = 2;

  // Width of the tag carried from AR to R
  localparam int ID_TAG_W = AXI_ID_W + AXI_USER_W;

  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [AXI_ID_W-1:0]   axi_id_t;
  typedef logic [AXI_USER_W-1:0] axi_user_t;

  // Read response codes
  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  // ID in the upper bits, user tag below it
  typedef logic [ID_TAG_W-1:0] id_tag_t;

endpackage

// File: src/regbank_pkg.sv
package regbank_pkg;

  // Word index sits above the byte-in-word bits of the address
  localparam int BYTE_OFS_W = $clog2(axi_pkg::AXI_DATA_W / 8);
  localparam int REG_IDX_W  = axi_pkg::AXI_ADDR_W - BYTE_OFS_W;

  // Populated words, indices from here up are undecoded
  localparam int NUM_REGS = 24;

  typedef logic [REG_IDX_W-1:0] reg_idx_t;

endpackage

// File: src/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer #(
  parameter int DATA_W = 8
) (
  input  logic              clk,
  input  logic              i_arst_n,

  input  logic              i_valid,
  input  logic [DATA_W-1:0] i_data,
  output logic              o_ready,

  output logic              o_valid,
  output logic [DATA_W-1:0] o_data,
  input  logic              i_ready
);

  logic              main_valid;
  logic [DATA_W-1:0] main_data;
  logic              skid_valid;
  logic [DATA_W-1:0] skid_data;

  logic              in_xfer;
  logic              main_free;
  logic              load_main;
  logic              load_skid;

  assign in_xfer = i_valid && o_ready;

  // Main register is empty or hands its beat downstream this cycle
  assign main_free = !main_valid || i_ready;

  // Skid entry always has priority, it is the older beat
  assign load_main = main_free && (skid_valid || in_xfer);

  // Downstream stalled while a new beat arrives
  assign load_skid = !main_free && in_xfer;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (main_free) begin
        main_valid <= skid_valid || in_xfer;
      end
      if (load_skid) begin
        skid_valid <= 1'b1;
      end else if (main_free) begin
        skid_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_main) begin
      main_data <= skid_valid ? skid_data : i_data;
    end
    if (load_skid) begin
      skid_data <= i_data;
    end
  end

  // Ready comes straight from a flop
  assign o_ready = !skid_valid;
  assign o_valid = main_valid;
  assign o_data  = main_data;

endmodule

// File: src/id_fifo.sv
`timescale 1ns/1ps

module id_fifo #(
  parameter int DEPTH_W = 2,
  parameter int DATA_W  = 8
) (
  input  logic              clk,
  input  logic              i_arst_n,

  input  logic              i_push,
  input  logic [DATA_W-1:0] i_push_data,
  output logic              o_full,

  input  logic              i_pop,
  output logic [DATA_W-1:0] o_pop_data,
  output logic              o_empty
);

  localparam int DEPTH = 2 ** DEPTH_W;

  logic [DATA_W-1:0] mem [DEPTH];

  // Extra top bit tells a wrapped writer from an equal one
  logic [DEPTH_W:0]   wr_ptr;
  logic [DEPTH_W:0]   rd_ptr;
  logic [DEPTH_W-1:0] wr_idx;
  logic [DEPTH_W-1:0] rd_idx;

  logic               push_en;
  logic               pop_en;

  assign wr_idx = wr_ptr[DEPTH_W-1:0];
  assign rd_idx = rd_ptr[DEPTH_W-1:0];

  assign o_empty = (wr_ptr == rd_ptr);
  assign o_full  = (wr_ptr[DEPTH_W] != rd_ptr[DEPTH_W]) && (wr_idx == rd_idx);

  // Overflow and underflow are dropped
  assign push_en = i_push && !o_full;
  assign pop_en  = i_pop && !o_empty;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_en) begin
      mem[wr_idx] <= i_push_data;
    end
  end

  // Head read without a register stage
  assign o_pop_data = mem[rd_idx];

endmodule

// File: src/axi_axil_reflect_rd.sv
`timescale 1ns/1ps

module axi_axil_reflect_rd (
  input  logic               clk,
  input  logic               i_arst_n,

  // AXI read subordinate
  input  logic               i_arvalid,
  input  axi_pkg::axi_id_t   i_arid,
  input  axi_pkg::axi_addr_t i_araddr,
  input  logic [7:0]         i_arlen,
  input  logic [2:0]         i_arsize,
  input  logic [1:0]         i_arburst,
  input  axi_pkg::axi_user_t i_aruser,
  output logic               o_arready,

  output logic               o_rvalid,
  output axi_pkg::axi_id_t   o_rid,
  output axi_pkg::axi_data_t o_rdata,
  output axi_pkg::axi_resp_t o_rresp,
  output axi_pkg::axi_user_t o_ruser,
  output logic               o_rlast,
  input  logic               i_rready,

  // AXI-Lite read manager
  output logic               o_axil_arvalid,
  output axi_pkg::axi_addr_t o_axil_araddr,
  input  logic               i_axil_arready,
  input  logic               i_axil_rvalid,
  input  axi_pkg::axi_data_t i_axil_rdata,
  input  axi_pkg::axi_resp_t i_axil_rresp,
  output logic               o_axil_rready
);

  logic             sb_ready;
  logic             fifo_full;
  logic             ar_xfer;
  logic             r_xfer;
  axi_pkg::id_tag_t push_tag;
  axi_pkg::id_tag_t head_tag;

  assign ar_xfer  = i_arvalid && o_arready;
  assign r_xfer   = o_rvalid && i_rready;
  assign push_tag = {i_arid, i_aruser};

  skid_buffer #(
    .DATA_W (axi_pkg::AXI_ADDR_W)
  ) u_ar_skid (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_valid  (ar_xfer),
    .i_data   (i_araddr),
    .o_ready  (sb_ready),
    .o_valid  (o_axil_arvalid),
    .o_data   (o_axil_araddr),
    .i_ready  (i_axil_arready)
  );

  // Tags of outstanding reads in request order
  id_fifo #(
    .DEPTH_W (axi_pkg::OUTSTANDING_W),
    .DATA_W  (axi_pkg::ID_TAG_W)
  ) u_id_fifo (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_push      (ar_xfer),
    .i_push_data (push_tag),
    .o_full      (fifo_full),
    .i_pop       (r_xfer),
    .o_pop_data  (head_tag),
    .o_empty     ()
  );

  assign o_arready = sb_ready && !fifo_full;

  // Return path passes straight through with the tag from the queue head
  assign o_rvalid      = i_axil_rvalid;
  assign o_rdata       = i_axil_rdata;
  assign o_rresp       = i_axil_rresp;
  assign o_rid         = head_tag[axi_pkg::ID_TAG_W-1 -: axi_pkg::AXI_ID_W];
  assign o_ruser       = head_tag[axi_pkg::AXI_USER_W-1:0];
  // Every read is a single beat whatever the burst fields say
  assign o_rlast       = 1'b1;
  assign o_axil_rready = i_rready;

endmodule

// File: src/axil_rd_regbank.sv
`timescale 1ns/1ps

module axil_rd_regbank (
  input  logic                  clk,
  input  logic                  i_arst_n,

  // AXI-Lite read subordinate
  input  logic                  i_axil_arvalid,
  input  axi_pkg::axi_addr_t    i_axil_araddr,
  output logic                  o_axil_arready,
  output logic                  o_axil_rvalid,
  output axi_pkg::axi_data_t    o_axil_rdata,
  output axi_pkg::axi_resp_t    o_axil_rresp,
  input  logic                  i_axil_rready,

  // Host write port
  input  logic                  i_wr_en,
  input  regbank_pkg::reg_idx_t i_wr_idx,
  input  axi_pkg::axi_data_t    i_wr_data
);

  axi_pkg::axi_data_t    regs [regbank_pkg::NUM_REGS];

  logic                  rvalid_q;
  logic                  ar_xfer;
  regbank_pkg::reg_idx_t rd_idx;
  logic                  rd_hit;
  logic                  wr_hit;

  // Word index from the upper address bits
  assign rd_idx = i_axil_araddr[axi_pkg::AXI_ADDR_W-1 -: regbank_pkg::REG_IDX_W];
  assign rd_hit = (rd_idx < regbank_pkg::NUM_REGS);
  assign wr_hit = i_wr_en && (i_wr_idx < regbank_pkg::NUM_REGS);

  // One response slot, refilled in the cycle it drains
  assign o_axil_arready = !rvalid_q || i_axil_rready;
  assign ar_xfer        = i_axil_arvalid && o_axil_arready;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < regbank_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_hit) begin
      regs[i_wr_idx] <= i_wr_data;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rvalid_q <= 1'b0;
    end else if (ar_xfer) begin
      rvalid_q <= 1'b1;
    end else if (i_axil_rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // Response payload captured at acceptance
  always_ff @(posedge clk) begin
    if (ar_xfer) begin
      if (rd_hit) begin
        o_axil_rdata <= regs[rd_idx];
        o_axil_rresp <= axi_pkg::RESP_OKAY;
      end else begin
        // Unpopulated word
        o_axil_rdata <= '0;
        o_axil_rresp <= axi_pkg::RESP_SLVERR;
      end
    end
  end

  assign o_axil_rvalid = rvalid_q;

endmodule

// File: src/axi_rd_bridge.sv
`timescale 1ns/1ps

module axi_rd_bridge (
  input  logic                  clk,
  input  logic                  i_arst_n,

  // AXI read address
  input  logic                  i_arvalid,
  input  axi_pkg::axi_id_t      i_arid,
  input  axi_pkg::axi_addr_t    i_araddr,
  input  logic [7:0]            i_arlen,
  input  logic [2:0]            i_arsize,
  input  logic [1:0]            i_arburst,
  input  axi_pkg::axi_user_t    i_aruser,
  output logic                  o_arready,

  // AXI read data
  output logic                  o_rvalid,
  output axi_pkg::axi_id_t      o_rid,
  output axi_pkg::axi_data_t    o_rdata,
  output axi_pkg::axi_resp_t    o_rresp,
  output axi_pkg::axi_user_t    o_ruser,
  output logic                  o_rlast,
  input  logic                  i_rready,

  // Host write port into the bank
  input  logic                  i_wr_en,
  input  regbank_pkg::reg_idx_t i_wr_idx,
  input  axi_pkg::axi_data_t    i_wr_data
);

  // Internal AXI-Lite read channel
  logic               axil_arvalid;
  axi_pkg::axi_addr_t axil_araddr;
  logic               axil_arready;
  logic               axil_rvalid;
  axi_pkg::axi_data_t axil_rdata;
  axi_pkg::axi_resp_t axil_rresp;
  logic               axil_rready;

  axi_axil_reflect_rd u_reflect (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_arvalid      (i_arvalid),
    .i_arid         (i_arid),
    .i_araddr       (i_araddr),
    .i_arlen        (i_arlen),
    .i_arsize       (i_arsize),
    .i_arburst      (i_arburst),
    .i_aruser       (i_aruser),
    .o_arready      (o_arready),
    .o_rvalid       (o_rvalid),
    .o_rid          (o_rid),
    .o_rdata        (o_rdata),
    .o_rresp        (o_rresp),
    .o_ruser        (o_ruser),
    .o_rlast        (o_rlast),
    .i_rready       (i_rready),
    .o_axil_arvalid (axil_arvalid),
    .o_axil_araddr  (axil_araddr),
    .i_axil_arready (axil_arready),
    .i_axil_rvalid  (axil_rvalid),
    .i_axil_rdata   (axil_rdata),
    .i_axil_rresp   (axil_rresp),
    .o_axil_rready  (axil_rready)
  );

  axil_rd_regbank u_regbank (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_axil_arvalid (axil_arvalid),
    .i_axil_araddr  (axil_araddr),
    .o_axil_arready (axil_arready),
    .o_axil_rvalid  (axil_rvalid),
    .o_axil_rdata   (axil_rdata),
    .o_axil_rresp   (axil_rresp),
    .i_axil_rready  (axil_rready),
    .i_wr_en        (i_wr_en),
    .i_wr_idx       (i_wr_idx),
    .i_wr_data      (i_wr_data)
  );

endmodule

// File: verif/tb_axi_rd_tasks.svh
`ifndef TB_AXI_RD_TASKS_SVH
`define TB_AXI_RD_TASKS_SVH

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic string mismatch(input string what, input logic [31:0] got, exp);
    return $sformatf("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
  endfunction

  task automatic check_id(input axi_pkg::axi_id_t got, exp, input string what);
    if (got !== exp) stop_on_failure(mismatch(what, got, exp));
  endtask

  task automatic check_user(input axi_pkg::axi_user_t got, exp, input string what);
    if (got !== exp) stop_on_failure(mismatch(what, got, exp));
  endtask

  task automatic check_data(input axi_pkg::axi_data_t got, exp, input string what);
    if (got !== exp) stop_on_failure(mismatch(what, got, exp));
  endtask

  task automatic check_resp(input axi_pkg::axi_resp_t got, exp, input string what);
    if (got !== exp) stop_on_failure(mismatch(what, got, exp));
  endtask

  task automatic check_bit(input logic got, exp, input string what);
    if (got !== exp) stop_on_failure(mismatch(what, got, exp));
  endtask

  task automatic host_write(input regbank_pkg::reg_idx_t idx, input axi_pkg::axi_data_t data);
    i_wr_en   = 1'b1;
    i_wr_idx  = idx;
    i_wr_data = data;
    @(posedge clk);
    ref_regs[idx] = data;
    #1;
    i_wr_en = 1'b0;
  endtask

  // Pushes the expected return, then holds AR until the handshake edge
  task automatic issue_read(input axi_pkg::axi_id_t id, input axi_pkg::axi_user_t user,
                            input axi_pkg::axi_addr_t addr, input logic [7:0] len,
                            input logic [2:0] size, input logic [1:0] burst);
    int idx;
    // Word index sits above the byte-in-word bit
    idx = addr >> 1;
    exp_id.push_back(id);
    exp_user.push_back(user);
    exp_data.push_back((idx < regbank_pkg::NUM_REGS) ? ref_regs[idx] : '0);
    exp_resp.push_back((idx < regbank_pkg::NUM_REGS) ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR);
    i_arvalid = 1'b1;
    i_arid    = id;
    i_aruser  = user;
    i_araddr  = addr;
    i_arlen   = len;
    i_arsize  = size;
    i_arburst = burst;
    @(negedge clk);
    while (!o_arready) @(negedge clk);
    @(posedge clk);
    #1;
    i_arvalid = 1'b0;
  endtask

  task automatic random_read(input logic [7:0] len, input logic [2:0] size,
                             input logic [1:0] burst);
    rnd_state = xorshift32(rnd_state);
    issue_read(rnd_state[3:0], rnd_state[5:4], rnd_state[11:6], len, size, burst);
  endtask

  // All returns in, then no stray beat follows
  task automatic wait_for_drain();
    while (exp_id.size() != 0) @(negedge clk);
    repeat (3) @(negedge clk);
    check_bit(o_rvalid, 1'b0, "o_rvalid after all returns");
    @(posedge clk);
    #1;
  endtask

  task automatic check_reset_state();
    check_bit(o_rvalid, 1'b0, "o_rvalid after reset");
    check_bit(o_arready, 1'b1, "o_arready after reset");
    issue_read(4'h3, 2'h1, 6'h0e, 8'd0, 3'd1, 2'd1);
    wait_for_drain();
  endtask

  task automatic read_loaded_word();
    for (int i = 0; i < regbank_pkg::NUM_REGS; i++) begin
      rnd_state = xorshift32(rnd_state);
      host_write(regbank_pkg::reg_idx_t'(i), rnd_state[15:0]);
    end
    issue_read(4'ha, 2'h2, 6'd22, 8'd0, 3'd1, 2'd1);
    @(negedge clk);
    check_bit(o_rvalid, 1'b0, "o_rvalid one cycle after AR");
    @(negedge clk);
    check_bit(o_rvalid, 1'b1, "o_rvalid two cycles after AR");
    wait_for_drain();
  endtask

  task automatic read_unmapped_words();
    for (int i = regbank_pkg::NUM_REGS; i < 32; i++) begin
      rnd_state = xorshift32(rnd_state);
      issue_read(rnd_state[3:0], rnd_state[5:4], axi_pkg::axi_addr_t'({i[4:0], rnd_state[6]}),
                 8'd0, 3'd1, 2'd1);
    end
    wait_for_drain();
  endtask

  task automatic run_back_to_back();
    repeat (40) random_read(8'd0, 3'd1, 2'd1);
    wait_for_drain();
  endtask

  task automatic run_with_backpressure();
    watch_arready    = 1'b1;
    arready_low_seen = 1'b0;
    stall_left       = 10;
    rready_random    = 1'b1;
    repeat (40) random_read(8'd0, 3'd1, 2'd1);
    wait_for_drain();
    rready_random = 1'b0;
    watch_arready = 1'b0;
    check_bit(arready_low_seen, 1'b1, "o_arready low during a stall");
  endtask

  task automatic read_with_burst_fields();
    int idx;
    repeat (8) begin
      rnd_state = xorshift32(rnd_state);
      idx = rnd_state[20:16] % regbank_pkg::NUM_REGS;
      issue_read(rnd_state[3:0], rnd_state[5:4], axi_pkg::axi_addr_t'(idx << 1),
                 rnd_state[15:8] | 8'h01, rnd_state[24:22] | 3'b001, rnd_state[26:25] | 2'b01);
      wait_for_drain();
    end
  endtask

`endif

// File: verif/tb_axi_rd_bridge.sv
`timescale 1ns/1ps

module tb_axi_rd_bridge;

  localparam int          CLK_PERIOD  = 40;
  localparam int          TIMEOUT_CYC = 4000;
  localparam logic [31:0] SEED        = 32'hc9697a84;

  logic                  clk;
  logic                  i_arst_n;
  logic                  i_arvalid;
  axi_pkg::axi_id_t      i_arid;
  axi_pkg::axi_addr_t    i_araddr;
  logic [7:0]            i_arlen;
  logic [2:0]            i_arsize;
  logic [1:0]            i_arburst;
  axi_pkg::axi_user_t    i_aruser;
  logic                  o_arready;
  logic                  o_rvalid;
  axi_pkg::axi_id_t      o_rid;
  axi_pkg::axi_data_t    o_rdata;
  axi_pkg::axi_resp_t    o_rresp;
  axi_pkg::axi_user_t    o_ruser;
  logic                  o_rlast;
  logic                  i_rready;
  logic                  i_wr_en;
  regbank_pkg::reg_idx_t i_wr_idx;
  axi_pkg::axi_data_t    i_wr_data;

  // Model of the bank over all 32 word slots
  axi_pkg::axi_data_t ref_regs [32];

  // Expected returns in request order
  axi_pkg::axi_id_t   exp_id   [$];
  axi_pkg::axi_user_t exp_user [$];
  axi_pkg::axi_data_t exp_data [$];
  axi_pkg::axi_resp_t exp_resp [$];

  logic [31:0] rnd_state;
  logic [31:0] rdy_state;
  logic        rready_random;
  logic        rready_mode;
  int          stall_left;
  logic        watch_arready;
  logic        arready_low_seen;
  int          cycles;

  axi_rd_bridge u_dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

`include "tb_axi_rd_tasks.svh"

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYC) begin
      stop_on_failure($sformatf("Timeout, the run did not finish in %0d cycles", TIMEOUT_CYC));
    end
  end

  // Mostly high rready with occasional 10 cycle stalls
  always @(posedge clk) begin
    rready_mode = rready_random;
    #1;
    if (!rready_mode) begin
      i_rready = 1'b1;
    end else if (stall_left > 0) begin
      i_rready   = 1'b0;
      stall_left = stall_left - 1;
    end else begin
      rdy_state = xorshift32(rdy_state);
      if (rdy_state[4:0] == 5'd0) begin
        stall_left = 9;
        i_rready   = 1'b0;
      end else begin
        i_rready = rdy_state[8] | rdy_state[9];
      end
    end
  end

  // R monitor samples mid-cycle where all signals are settled
  always @(negedge clk) begin
    if (i_arst_n && o_rvalid && i_rready) begin
      if (exp_id.size() == 0) begin
        stop_on_failure($sformatf("A return at %0t ns came with no read outstanding", $time));
      end else begin
        check_id(o_rid, exp_id.pop_front(), "o_rid");
        check_user(o_ruser, exp_user.pop_front(), "o_ruser");
        check_data(o_rdata, exp_data.pop_front(), "o_rdata");
        check_resp(o_rresp, exp_resp.pop_front(), "o_rresp");
        check_bit(o_rlast, 1'b1, "o_rlast");
      end
    end
    if (watch_arready && !o_arready) begin
      arready_low_seen = 1'b1;
    end
  end

  initial begin
    clk              = 1'b0;
    i_arst_n         = 1'b0;
    i_arvalid        = 1'b0;
    i_arid           = '0;
    i_araddr         = '0;
    i_arlen          = '0;
    i_arsize         = '0;
    i_arburst        = '0;
    i_aruser         = '0;
    i_rready         = 1'b1;
    i_wr_en          = 1'b0;
    i_wr_idx         = '0;
    i_wr_data        = '0;
    rnd_state        = SEED;
    rdy_state        = SEED;
    rready_random    = 1'b0;
    stall_left       = 0;
    watch_arready    = 1'b0;
    arready_low_seen = 1'b0;
    cycles           = 0;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    i_arst_n = 1'b1;
    check_reset_state();
    read_loaded_word();
    read_unmapped_words();
    run_back_to_back();
    run_with_backpressure();
    read_with_burst_fields();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: axi_rd_bridge.f
+incdir+verif
src/axi_pkg.sv
src/regbank_pkg.sv
src/skid_buffer.sv
src/id_fifo.sv
src/axi_axil_reflect_rd.sv
src/axil_rd_regbank.sv
src/axi_rd_bridge.sv
verif/tb_axi_rd_bridge.sv
